// ==== source/uart_pkg.sv ====
package uart_pkg;

    // one bus request, driven by the master
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;             // byte lane enables
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // received byte handed from the receiver to the register block
    typedef struct packed {
        logic [7:0] data;
        logic       valid;            // one-cycle pulse
    } rx_byte_t;

    // decoded target register of a bus access
    typedef enum logic [1:0] {
        reg_none,
        reg_div,
        reg_dat,
        reg_cfg
    } reg_sel_e;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,                     // waiting for the middle of the start bit
        rx_data,
        rx_stop
    } rx_state_e;

    localparam logic [31:0] div_ofs = 32'h0000_0000;
    localparam logic [31:0] dat_ofs = 32'h0000_0004;
    localparam logic [31:0] cfg_ofs = 32'h0000_0008;

    localparam logic [31:0] div_reset  = 32'd1;
    localparam int unsigned guard_bits = 15;   // idle bit times after reset or divider change

endpackage

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] div_value_i,
    input  logic        tx_start_i,
    input  logic [7:0]  tx_data_i,
    input  logic        guard_req_i,
    output logic        ser_tx_o,
    output logic        tx_busy_o
);
    import uart_pkg::*;

    logic [9:0]  frame_q;                 // bit 0 is on the line
    logic [3:0]  bit_cnt_q;               // bit times left in the current run
    logic [31:0] div_cnt_q;
    logic        guard_pend_q;
    logic        bit_end;

    // a bit time is div_value_i + 2 cycles
    assign bit_end = div_cnt_q > div_value_i;

    assign ser_tx_o  = frame_q[0];
    assign tx_busy_o = (bit_cnt_q != 4'd0) || guard_pend_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_q      <= '1;
            bit_cnt_q    <= 4'd0;
            div_cnt_q    <= '0;
            guard_pend_q <= 1'b1;         // idle run right after reset
        end else begin
            div_cnt_q <= div_cnt_q + 32'd1;
            if (guard_req_i) begin
                guard_pend_q <= 1'b1;
            end
            if (bit_cnt_q == 4'd0) begin
                if (guard_pend_q) begin
                    // guard run, line stays high
                    frame_q      <= '1;
                    bit_cnt_q    <= 4'(guard_bits);
                    div_cnt_q    <= '0;
                    guard_pend_q <= guard_req_i;
                end else if (tx_start_i) begin
                    frame_q   <= {1'b1, tx_data_i, 1'b0};   // stop, data lsb first, start
                    bit_cnt_q <= 4'd10;
                    div_cnt_q <= '0;
                end
            end else if (bit_end) begin
                frame_q   <= {1'b1, frame_q[9:1]};          // shift in idle level
                bit_cnt_q <= bit_cnt_q - 4'd1;
                div_cnt_q <= '0;
            end
        end
    end

    a_idle_line_high : assert property (
        @(posedge clk) disable iff (!resetn)
        !tx_busy_o |-> ser_tx_o
    ) else $error("serial line low while transmitter idle");

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
    input  logic               clk,
    input  logic               resetn,
    input  logic [31:0]        div_value_i,
    input  logic               enabled_i,
    input  logic               ser_rx_i,
    output uart_pkg::rx_byte_t rx_byte_o
);
    import uart_pkg::*;

    rx_state_e   state_q;
    logic [31:0] div_cnt_q;
    logic [2:0]  bit_cnt_q;
    logic [7:0]  shift_q;
    logic [7:0]  data_q;
    logic        valid_q;
    logic        half_end;
    logic        bit_end;

    // half a bit time to reach the middle of the start bit
    assign half_end = {div_cnt_q, 1'b0} > {1'b0, div_value_i};
    assign bit_end  = div_cnt_q > div_value_i;

    assign rx_byte_o.data  = data_q;
    assign rx_byte_o.valid = valid_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q   <= rx_idle;
            div_cnt_q <= '0;
            bit_cnt_q <= 3'd0;
            valid_q   <= 1'b0;
        end else begin
            valid_q   <= 1'b0;
            div_cnt_q <= div_cnt_q + 32'd1;
            unique case (state_q)
                rx_idle: begin
                    div_cnt_q <= '0;
                    if (!ser_rx_i && enabled_i) begin
                        state_q <= rx_start;
                    end
                end
                rx_start: begin
                    if (half_end) begin
                        state_q   <= rx_data;
                        div_cnt_q <= '0;
                        bit_cnt_q <= 3'd0;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        div_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= rx_stop;   // last data bit taken
                        end
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        valid_q <= 1'b1;
                        state_q <= rx_idle;
                    end
                end
                default: state_q <= rx_idle;
            endcase
        end
    end

    // data path, no reset needed
    always_ff @(posedge clk) begin
        if (state_q == rx_data && bit_end) begin
            shift_q <= {ser_rx_i, shift_q[7:1]};  // lsb arrives first
        end
        if (state_q == rx_stop && bit_end) begin
            data_q <= shift_q;
        end
    end

    a_valid_pulse : assert property (
        @(posedge clk) disable iff (!resetn)
        rx_byte_o.valid |=> !rx_byte_o.valid
    ) else $error("rx valid held for more than one cycle");

endmodule

// ==== source/uart_wb_regs.sv ====
`timescale 1ns/10ps

module uart_wb_regs #(
    parameter logic [31:0] base_adr = 32'h2000_0000
) (
    input  logic               clk,
    input  logic               resetn,
    input  uart_pkg::wb_req_t  bus_i,
    output uart_pkg::wb_rsp_t  bus_o,
    input  logic               tx_busy_i,
    input  uart_pkg::rx_byte_t rx_byte_i,
    output logic               tx_start_o,
    output logic [7:0]         tx_data_o,
    output logic               guard_req_o,
    output logic [31:0]        div_value_o,
    output logic               enabled_o
);
    import uart_pkg::*;

    reg_sel_e    sel_e;
    logic        valid;
    logic [3:0]  div_we;
    logic        cfg_we;
    logic        dat_we;
    logic        dat_re;
    logic        ack;
    logic [31:0] rd_dat;

    logic [31:0] div_q;
    logic        enabled_q;
    logic [7:0]  rx_buf_q;
    logic        rx_full_q;              // receive buffer holds an unread byte

    assign valid = bus_i.cyc && bus_i.stb;

    // address decode, exact match against base_adr | offset
    always_comb begin
        sel_e = reg_none;
        if (valid) begin
            if (bus_i.adr == (base_adr | div_ofs)) begin
                sel_e = reg_div;
            end else if (bus_i.adr == (base_adr | dat_ofs)) begin
                sel_e = reg_dat;
            end else if (bus_i.adr == (base_adr | cfg_ofs)) begin
                sel_e = reg_cfg;
            end
        end
    end

    assign div_we = (sel_e == reg_div && bus_i.we) ? bus_i.sel : 4'b0000;
    assign cfg_we = (sel_e == reg_cfg) && bus_i.we && bus_i.sel[0];
    assign dat_we = (sel_e == reg_dat) && bus_i.we && bus_i.sel[0];
    assign dat_re = (sel_e == reg_dat) && !bus_i.we;

    // a data write waits here until the transmitter is free
    assign ack = (sel_e != reg_none) && !(dat_we && tx_busy_i);

    always_comb begin
        rd_dat = '0;
        unique case (sel_e)
            reg_div:  rd_dat = div_q;
            reg_cfg:  rd_dat = {31'd0, enabled_q};
            reg_dat:  rd_dat = rx_full_q ? {24'd0, rx_buf_q} : '1;   // empty reads all ones
            default:  rd_dat = '0;
        endcase
    end

    assign bus_o.ack = ack;
    assign bus_o.dat = rd_dat;

    assign tx_start_o  = dat_we && !tx_busy_i;    // same cycle the write is acked
    assign tx_data_o   = bus_i.dat[7:0];
    assign guard_req_o = (|div_we) && enabled_q;   // let the far end resync on the new rate
    assign div_value_o = div_q;
    assign enabled_o   = enabled_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_q     <= div_reset;
            enabled_q <= 1'b0;
            rx_full_q <= 1'b0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (div_we[i]) begin
                    div_q[i*8 +: 8] <= bus_i.dat[i*8 +: 8];
                end
            end
            if (cfg_we) begin
                enabled_q <= bus_i.dat[0];
            end
            if (dat_re) begin
                rx_full_q <= 1'b0;
            end
            // a fresh byte wins over a read in the same cycle
            if (rx_byte_i.valid) begin
                rx_full_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_byte_i.valid) begin
            rx_buf_q <= rx_byte_i.data;              // overwrites an unread byte
        end
    end

    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!resetn)
        bus_o.ack |-> (bus_i.cyc && bus_i.stb)
    ) else $error("ack without an active request");

    // a start is only issued to an idle transmitter, which then reports busy
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!resetn)
        tx_start_o |-> !tx_busy_i ##1 tx_busy_i
    ) else $error("tx_start issued while transmitter busy or not taken");

endmodule

// ==== source/uart_wb_top.sv ====
`timescale 1ns/10ps

module uart_wb_top #(
    parameter logic [31:0] base_adr = 32'h2000_0000
) (
    input  logic              clk,
    input  logic              resetn,
    input  uart_pkg::wb_req_t bus_i,
    output uart_pkg::wb_rsp_t bus_o,
    input  logic              ser_rx_i,
    output logic              ser_tx_o,
    output logic              enabled_o
);
    import uart_pkg::*;

    logic        tx_start;
    logic [7:0]  tx_data;
    logic        guard_req;
    logic        tx_busy;
    logic [31:0] div_value;
    logic        enabled;
    rx_byte_t    rx_byte;

    assign enabled_o = enabled;

    uart_wb_regs #(
        .base_adr   (base_adr)
    ) i_regs (
        .clk         (clk),
        .resetn      (resetn),
        .bus_i       (bus_i),
        .bus_o       (bus_o),
        .tx_busy_i   (tx_busy),
        .rx_byte_i   (rx_byte),
        .tx_start_o  (tx_start),
        .tx_data_o   (tx_data),
        .guard_req_o (guard_req),
        .div_value_o (div_value),
        .enabled_o   (enabled)
    );

    uart_tx i_tx (
        .clk         (clk),
        .resetn      (resetn),
        .div_value_i (div_value),
        .tx_start_i  (tx_start),
        .tx_data_i   (tx_data),
        .guard_req_i (guard_req),
        .ser_tx_o    (ser_tx_o),
        .tx_busy_o   (tx_busy)
    );

    uart_rx i_rx (
        .clk         (clk),
        .resetn      (resetn),
        .div_value_i (div_value),
        .enabled_i   (enabled),     // receiver only listens while the port is on
        .ser_rx_i    (ser_rx_i),
        .rx_byte_o   (rx_byte)
    );

endmodule

// ==== testbench/tb_uart_wb.sv ====
`timescale 1ns/10ps

module tb_uart_wb;
    import uart_pkg::*;

    localparam logic [31:0] base_adr     = 32'h4001_0000;
    localparam int          div_test     = 3;               // short bit time for the tests
    localparam int          bit_cycles   = div_test + 2;
    localparam int          frame_cycles = 10 * bit_cycles;
    localparam int          loop_bytes   = 4;
    localparam int          bytes_sent   = loop_bytes + 3;  // loopback, disabled, back-pressure
    localparam int          margin_bits  = 80;              // reset guard, polls and idle waits
    localparam int          timeout_cycles =
        ((guard_bits + 10) * bytes_sent + margin_bits) * bit_cycles * 2;
    localparam int          rx_budget    = 20 * bit_cycles;  // polls before giving up on a byte
    localparam int          stall_limit  = (guard_bits + 12) * bit_cycles;

    logic    clk;
    logic    resetn;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    logic    ser_line;                                       // tx looped back into rx
    logic    enabled;

    int errors;
    int tests_run;
    int tests_bad;

    uart_wb_top #(
        .base_adr  (base_adr)
    ) i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .bus_i     (bus_req),
        .bus_o     (bus_rsp),
        .ser_rx_i  (ser_line),
        .ser_tx_o  (ser_line),
        .enabled_o (enabled)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run still going after %0d cycles", timeout_cycles);
        $display("Test failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic bus_xfer(
        input  logic [31:0] adr,
        input  logic [31:0] dat,
        input  logic [3:0]  sel,
        input  logic        we,
        input  int          max_cycles,
        output logic [31:0] rdat,
        output logic        acked,
        output int          waited
    );
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        bus_req.adr = adr;
        bus_req.dat = dat;
        bus_req.sel = sel;
        bus_req.we  = we;
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        while (!acked && waited < max_cycles) begin
            #2;                                     // ack is combinational, let it settle
            if (bus_rsp.ack) begin
                acked = 1'b1;
                rdat  = bus_rsp.dat;
            end
            @(negedge clk);                         // rising edge in between takes the access
            if (!acked) begin
                waited++;
            end
        end
        bus_req.cyc = 1'b0;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output int stall);
        logic [31:0] rd;
        logic        acked;
        bus_xfer(adr, dat, sel, 1'b1, stall_limit, rd, acked, stall);
        if (!acked) begin
            report_problem($sformatf("write to %h never acknowledged", adr));
        end
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rd);
        logic acked;
        int   waited;
        bus_xfer(adr, 32'h0, 4'hf, 1'b0, 4, rd, acked, waited);
        if (!acked) begin
            report_problem($sformatf("read from %h never acknowledged", adr));
        end
    endtask

    // each poll is a data read, so a returned byte is already taken from the buffer
    task automatic wait_rx(output logic [31:0] val, output int polls);
        polls = 0;
        val   = 32'hffff_ffff;
        while (val == 32'hffff_ffff && polls < rx_budget) begin
            bus_read(base_adr | dat_ofs, val);
            polls++;
        end
    endtask

    task automatic test_reset_values;
        int          errs;
        logic [31:0] rd;
        errs = errors;
        bus_read(base_adr | div_ofs, rd);
        if (rd !== 32'd1)
            report_mismatch("div", 32'd1, rd);
        bus_read(base_adr | cfg_ofs, rd);
        if (rd !== 32'd0)
            report_mismatch("cfg", 32'd0, rd);
        if (enabled !== 1'b0)
            report_mismatch("enabled_o", 32'd0, {31'd0, enabled});
        bus_read(base_adr | dat_ofs, rd);
        if (rd !== 32'hffff_ffff)
            report_mismatch("dat", 32'hffff_ffff, rd);
        repeat (guard_bits * 3 + 4) @(negedge clk);    // guard run at the reset divider
        if (ser_line !== 1'b1)
            report_mismatch("ser_tx_o", 32'd1, {31'd0, ser_line});
        finish_test("reset_values", errs);
    endtask

    task automatic test_div_lanes;
        int          errs;
        int          lane;
        int          stall;
        logic [7:0]  b;
        logic [31:0] rd;
        logic [31:0] exp;
        errs = errors;
        lane = $urandom % 4;
        b    = 8'($urandom % 255);                      // never all ones, so the change shows
        bus_write(base_adr | div_ofs, 32'hffff_ffff, 4'hf, stall);
        bus_write(base_adr | div_ofs, {4{b}}, 4'b0001 << lane, stall);
        exp = 32'hffff_ffff;
        exp[lane*8 +: 8] = b;
        bus_read(base_adr | div_ofs, rd);
        if (rd !== exp)
            report_mismatch("div", exp, rd);
        bus_write(base_adr | div_ofs, div_test, 4'hf, stall);
        finish_test("div_lanes", errs);
    endtask

    task automatic test_loopback;
        int          errs;
        int          i;
        int          stall;
        int          polls;
        logic [7:0]  b;
        logic [31:0] rd;
        errs = errors;
        bus_write(base_adr | cfg_ofs, 32'd1, 4'h1, stall);
        if (enabled !== 1'b1)
            report_mismatch("enabled_o", 32'd1, {31'd0, enabled});
        for (i = 0; i < loop_bytes; i++) begin
            b = 8'($urandom);
            bus_write(base_adr | dat_ofs, {24'd0, b}, 4'h1, stall);
            wait_rx(rd, polls);
            if (rd !== {24'd0, b})
                report_mismatch("dat", {24'd0, b}, rd);
            bus_read(base_adr | dat_ofs, rd);
            if (rd !== 32'hffff_ffff)
                report_mismatch("dat after read", 32'hffff_ffff, rd);
        end
        finish_test("loopback", errs);
    endtask

    task automatic test_disabled;
        int          errs;
        int          stall;
        int          polls;
        logic [31:0] rd;
        errs = errors;
        bus_write(base_adr | cfg_ofs, 32'd0, 4'h1, stall);
        bus_write(base_adr | dat_ofs, {24'd0, 8'($urandom)}, 4'h1, stall);
        wait_rx(rd, polls);                             // runs well past one frame
        if (rd !== 32'hffff_ffff)
            report_mismatch("dat while disabled", 32'hffff_ffff, rd);
        finish_test("disabled", errs);
    endtask

    task automatic test_back_pressure;
        int          errs;
        int          stall;
        int          polls;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [31:0] rd;
        errs = errors;
        b0 = 8'($urandom);
        b1 = 8'($urandom);
        bus_write(base_adr | cfg_ofs, 32'd1, 4'h1, stall);
        bus_write(base_adr | dat_ofs, {24'd0, b0}, 4'h1, stall);
        if (stall != 0)
            report_problem($sformatf("first write stalled %0d cycles on an idle port", stall));
        bus_write(base_adr | dat_ofs, {24'd0, b1}, 4'h1, stall);
        if (stall < frame_cycles - 1)
            report_problem($sformatf("second write acked after %0d cycles, frame is %0d",
                                     stall, frame_cycles));
        wait_rx(rd, polls);
        if (polls >= frame_cycles)
            report_problem("first byte not ready before the second frame ended");
        if (rd !== {24'd0, b0})
            report_mismatch("dat first byte", {24'd0, b0}, rd);
        wait_rx(rd, polls);
        if (rd !== {24'd0, b1})
            report_mismatch("dat second byte", {24'd0, b1}, rd);
        finish_test("back_pressure", errs);
    endtask

    task automatic test_unmapped;
        int          errs;
        int          waited;
        logic        acked;
        logic [31:0] rd;
        errs = errors;
        bus_xfer(base_adr | 32'h0000_000c, 32'h0, 4'hf, 1'b0, 8, rd, acked, waited);
        if (acked)
            report_problem("unmapped address was acknowledged");
        finish_test("unmapped", errs);
    endtask

    initial begin
        int seed_dummy;
        bus_req    = '0;
        resetn     = 1'b0;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        seed_dummy = $urandom(32'h932eadd5);
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        test_reset_values();
        test_div_lanes();
        test_loopback();
        test_disabled();
        test_back_pressure();
        test_unmapped();
        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_wb_regs.sv
source/uart_wb_top.sv
testbench/tb_uart_wb.sv
